//--- src.f
hw/mem_bridge_pkg.sv
hw/reset_stretch.sv
hw/req_arbiter.sv
hw/axi_single_beat.sv
hw/mem_bridge_top.sv
test/axi_mem_model.sv
test/mem_bridge_checker.sv
test/tb_mem_bridge.sv

//--- Makefile
SRCS := $(shell cat src.f)

obj_dir/Vtb_mem_bridge: src.f $(SRCS)
	verilator --binary --timing --assert -f src.f --top-module tb_mem_bridge

run: obj_dir/Vtb_mem_bridge
	./obj_dir/Vtb_mem_bridge +verilator+error+limit+100 | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- test/tb_mem_bridge.sv
`timescale 1ns/10ps

module tb_mem_bridge;

    logic                    Clk = 1'b0;
    logic                    aresetn;
    logic                    inst_req_i, inst_addr_ok_o, inst_data_ok_o;
    mem_bridge_pkg::addr_t   inst_addr_i;
    mem_bridge_pkg::word_t   inst_rdata_o;
    logic                    data_req_i, data_wr_i, data_addr_ok_o, data_data_ok_o;
    mem_bridge_pkg::size_t   data_size_i;
    mem_bridge_pkg::addr_t   data_addr_i;
    mem_bridge_pkg::word_t   data_wdata_i, data_rdata_o;
    mem_bridge_pkg::axi_id_t arid_o;
    mem_bridge_pkg::addr_t   araddr_o, awaddr_o;
    mem_bridge_pkg::size_t   arsize_o, awsize_o;
    mem_bridge_pkg::word_t   rdata_i, wdata_o;
    mem_bridge_pkg::strb_t   wstrb_o;
    logic                    arvalid_o, arready_i, rvalid_i, rready_o, awvalid_o, awready_i;
    logic                    wvalid_o, wready_i, bvalid_i, bready_o;
    logic [4:0]              stall;

    logic [15:0]             lfsr = 16'd62;
    logic [31:0]             shadow [64];
    mem_bridge_pkg::axi_id_t exp_id;
    mem_bridge_pkg::size_t   exp_size;
    mem_bridge_pkg::addr_t   exp_addr;
    mem_bridge_pkg::strb_t   exp_strb;
    int                      errors = 0;
    int                      timeouts = 0;

    mem_bridge_top i_mem_bridge_top (.*);

    axi_mem_model i_axi_mem_model (
        .Clk       (Clk),
        .aresetn   (aresetn),
        .stall_i   (stall),
        .araddr_i  (araddr_o),
        .arvalid_i (arvalid_o),
        .arready_o (arready_i),
        .rdata_o   (rdata_i),
        .rvalid_o  (rvalid_i),
        .rready_i  (rready_o),
        .awaddr_i  (awaddr_o),
        .awvalid_i (awvalid_o),
        .awready_o (awready_i),
        .wdata_i   (wdata_o),
        .wstrb_i   (wstrb_o),
        .wvalid_i  (wvalid_o),
        .wready_o  (wready_i),
        .bvalid_o  (bvalid_i),
        .bready_i  (bready_o)
    );

    initial begin
        forever #5 Clk = ~Clk;
    end

    // ******************************
    // helpers
    // ******************************
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // next falling edge, with fresh slave stalls.
    task automatic tick();
        logic [31:0] r;
        @(negedge Clk);
        take_bits(5, r);
        stall = r[4:0];
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    // byte lanes a store of this size touches at this address.
    function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [31:0] addr);
        logic [3:0] m;
        for (int b = 0; b < 4; b++) begin
            case (size)
                mem_bridge_pkg::SIZE_BYTE: m[b] = (b == addr[1:0]);
                mem_bridge_pkg::SIZE_HALF: m[b] = (b / 2 == addr[1]);
                default:                   m[b] = 1'b1;
            endcase
        end
        return m;
    endfunction

    function automatic logic watched(input int sel);
        case (sel)
            0:       return inst_addr_ok_o;
            1:       return data_addr_ok_o;
            2:       return inst_data_ok_o;
            default: return data_data_ok_o;
        endcase
    endfunction

    // returns on the rising edge that samples the strobe high.
    task automatic wait_for(input int sel, output int n);
        n = 1;
        @(posedge Clk);
        while (!watched(sel) && n < 300) begin
            tick();
            @(posedge Clk);
            n++;
        end
        if (!watched(sel)) begin
            timeouts++;
            $display("timeout at %0t: handshake strobe %0d never came", $time, sel);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] addr);
        assert (got == shadow[addr[7:2]])
            else report_mismatch($sformatf("read %h at %h, expected %h",
                                           got, addr, shadow[addr[7:2]]));
    endtask

    task automatic access(input logic is_data, input logic wr, input logic [1:0] size,
                          input logic [31:0] addr, input logic [31:0] wd);
        int         n;
        exp_id   = is_data ? mem_bridge_pkg::ID_DATA : mem_bridge_pkg::ID_INST;
        exp_size = size;
        exp_addr = addr;
        exp_strb = lane_mask(size, addr);
        if (is_data) begin
            data_req_i   = 1'b1;
            data_wr_i    = wr;
            data_size_i  = size;
            data_addr_i  = addr;
            data_wdata_i = wd;
        end else begin
            inst_req_i  = 1'b1;
            inst_addr_i = addr;
        end
        wait_for(is_data ? 1 : 0, n);
        tick();
        data_req_i = 1'b0;
        inst_req_i = 1'b0;
        wait_for(is_data ? 3 : 2, n);
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (exp_strb[b]) begin
                    shadow[addr[7:2]][8*b +: 8] = wd[8*b +: 8];
                end
            end
        end else begin
            check_word(is_data ? data_rdata_o : inst_rdata_o, addr);
        end
        tick();
    endtask

    // both ports at once while idle, data must win.
    task automatic dual_read(input logic [31:0] daddr, input logic [31:0] iaddr);
        int n;
        exp_id      = mem_bridge_pkg::ID_DATA;
        exp_size    = mem_bridge_pkg::SIZE_WORD;
        exp_addr    = daddr;
        data_req_i  = 1'b1;
        data_wr_i   = 1'b0;
        data_size_i = mem_bridge_pkg::SIZE_WORD;
        data_addr_i = daddr;
        inst_req_i  = 1'b1;
        inst_addr_i = iaddr;
        wait_for(1, n);
        assert (n == 1 && !inst_addr_ok_o)
            else report_mismatch("data port did not win the tie");
        tick();
        data_req_i = 1'b0;
        wait_for(3, n);
        check_word(data_rdata_o, daddr);
        exp_id   = mem_bridge_pkg::ID_INST;
        exp_addr = iaddr;
        if (!inst_addr_ok_o) begin
            tick();
            wait_for(0, n);
        end
        tick();
        inst_req_i = 1'b0;
        wait_for(2, n);
        check_word(inst_rdata_o, iaddr);
        tick();
    endtask

    // channel payload against what was issued.
    always @(posedge Clk) begin
        if (arvalid_o && arready_i) begin
            assert (arid_o == exp_id && arsize_o == exp_size && araddr_o == exp_addr)
                else report_mismatch($sformatf("read id %0d size %0d addr %h",
                                               arid_o, arsize_o, araddr_o));
        end
        if (awvalid_o && awready_i) begin
            assert (awsize_o == exp_size && awaddr_o == exp_addr)
                else report_mismatch($sformatf("write size %0d addr %h", awsize_o, awaddr_o));
        end
        if (wvalid_o && wready_i) begin
            assert (wstrb_o == exp_strb)
                else report_mismatch($sformatf("write strobe %b, expected %b",
                                               wstrb_o, exp_strb));
        end
    end

    // ******************************
    // stimulus
    // ******************************
    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] s;
        logic [31:0] w;
        int          n;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = 32'h9e3779b9 * (i + 1);
        end
        aresetn      = 1'b0;
        stall        = '0;
        inst_req_i   = 1'b0;
        inst_addr_i  = '0;
        data_wr_i    = 1'b0;
        data_wdata_i = '0;
        // a read is already held while reset is low.
        data_req_i   = 1'b1;
        data_size_i  = mem_bridge_pkg::SIZE_WORD;
        data_addr_i  = '0;
        exp_id       = mem_bridge_pkg::ID_DATA;
        exp_size     = mem_bridge_pkg::SIZE_WORD;
        exp_addr     = '0;
        exp_strb     = '0;
        repeat (3) tick();
        aresetn = 1'b1;
        wait_for(1, n);
        assert (n == mem_bridge_pkg::STRETCH_CYCLES + 1)
            else report_mismatch($sformatf("first accept after %0d edges", n));
        tick();
        data_req_i = 1'b0;
        wait_for(3, n);
        check_word(data_rdata_o, 32'h0);
        tick();

        for (int k = 0; k < 40; k++) begin
            take_bits(2, r);
            take_bits(8, a);
            take_bits(2, s);
            if (s == 3) begin
                s = mem_bridge_pkg::SIZE_WORD;
            end
            // align to the size.
            if (s == mem_bridge_pkg::SIZE_WORD) begin
                a[1:0] = 2'b00;
            end else if (s == mem_bridge_pkg::SIZE_HALF) begin
                a[0] = 1'b0;
            end
            case (r[1:0])
                2'd0, 2'd1: begin
                    take_bits(32, w);
                    access(1'b1, 1'b1, s[1:0], a, w);
                    access(1'b1, 1'b0, mem_bridge_pkg::SIZE_WORD, {a[31:2], 2'b00}, '0);
                    access(1'b0, 1'b0, mem_bridge_pkg::SIZE_WORD, {a[31:2], 2'b00}, '0);
                end
                2'd2: access(1'b1, 1'b0, s[1:0], a, '0);
                default: begin
                    take_bits(6, w);
                    dual_read({a[31:2], 2'b00}, {24'h0, w[5:0], 2'b00});
                end
            endcase
        end

        errors += i_mem_bridge_top.i_checker.fail_count;
        $display("%0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- test/mem_bridge_checker.sv
`timescale 1ns/10ps

module mem_bridge_checker (
    input  logic                    Clk,
    input  logic                    aresetn,
    input  logic                    inst_addr_ok_o,
    input  logic                    inst_data_ok_o,
    input  logic                    data_addr_ok_o,
    input  logic                    data_data_ok_o,
    input  mem_bridge_pkg::axi_id_t arid_o,
    input  mem_bridge_pkg::addr_t   araddr_o,
    input  mem_bridge_pkg::size_t   arsize_o,
    input  logic                    arvalid_o,
    input  logic                    arready_i,
    input  logic                    rready_o,
    input  mem_bridge_pkg::addr_t   awaddr_o,
    input  mem_bridge_pkg::size_t   awsize_o,
    input  logic                    awvalid_o,
    input  logic                    awready_i,
    input  mem_bridge_pkg::word_t   wdata_o,
    input  mem_bridge_pkg::strb_t   wstrb_o,
    input  logic                    wvalid_o,
    input  logic                    wready_i,
    input  logic                    bready_o
);

    int                    fail_count = 0;
    logic                  pend_q;
    logic                  pend_data_q;
    logic                  any_ok;
    logic                  any_done;

    assign any_ok   = inst_addr_ok_o | data_addr_ok_o;
    assign any_done = inst_data_ok_o | data_data_ok_o;

    // one request in flight, owned by one port.
    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            pend_q      <= 1'b0;
            pend_data_q <= 1'b0;
        end else if (any_ok) begin
            pend_q      <= 1'b1;
            pend_data_q <= data_addr_ok_o;
        end else if (any_done) begin
            pend_q <= 1'b0;
        end
    end

    // ******************************
    // handshake rules
    // ******************************
    a_reset_idle: assert property (@(posedge Clk)
        !aresetn |=> !(arvalid_o || awvalid_o || wvalid_o || rready_o || bready_o
                       || any_ok || any_done))
        else begin
            $error("bus or port strobes not idle after reset");
            fail_count++;
        end

    a_one_owner: assert property (@(posedge Clk) !(inst_addr_ok_o && data_addr_ok_o))
        else begin
            $error("both ports accepted in one cycle");
            fail_count++;
        end

    a_ok_after_done: assert property (@(posedge Clk) disable iff (!aresetn)
        any_ok |-> (!pend_q || any_done))
        else begin
            $error("request accepted while another is pending");
            fail_count++;
        end

    a_done_owner: assert property (@(posedge Clk) disable iff (!aresetn)
        any_done |-> (pend_q && !(inst_data_ok_o && data_data_ok_o)
                      && (data_data_ok_o == pend_data_q)))
        else begin
            $error("data_ok on the wrong port or with nothing pending");
            fail_count++;
        end

    a_stretch: assert property (@(posedge Clk)
        $rose(aresetn) |-> ##(mem_bridge_pkg::STRETCH_CYCLES) any_ok)
        else begin
            $error("first request not accepted after the reset stretch");
            fail_count++;
        end

    a_ar_hold: assert property (@(posedge Clk) disable iff (!aresetn)
        arvalid_o && !arready_i |=> arvalid_o && $stable({arid_o, araddr_o, arsize_o}))
        else begin
            $error("ar channel dropped or changed before arready");
            fail_count++;
        end

    a_aw_hold: assert property (@(posedge Clk) disable iff (!aresetn)
        awvalid_o && !awready_i |=> awvalid_o && $stable({awaddr_o, awsize_o}))
        else begin
            $error("aw channel dropped or changed before awready");
            fail_count++;
        end

    a_w_hold: assert property (@(posedge Clk) disable iff (!aresetn)
        wvalid_o && !wready_i |=> wvalid_o && $stable({wdata_o, wstrb_o}))
        else begin
            $error("w channel dropped or changed before wready");
            fail_count++;
        end

    a_read_id: assert property (@(posedge Clk) disable iff (!aresetn)
        arvalid_o |-> (arid_o == mem_bridge_pkg::ID_DATA)
                      || (arid_o == mem_bridge_pkg::ID_INST
                          && arsize_o == mem_bridge_pkg::SIZE_WORD))
        else begin
            $error("bad read id or fetch size");
            fail_count++;
        end

endmodule

bind mem_bridge_top mem_bridge_checker i_checker (.*);

//--- test/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model (
    input  logic        Clk,
    input  logic        aresetn,
    input  logic [4:0]  stall_i,
    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    input  logic [31:0] awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic        bvalid_o,
    input  logic        bready_i
);

    logic [31:0] mem [64];
    logic [5:0]  rd_idx_q;
    logic [5:0]  wr_idx_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    logic        rd_pend_q;
    logic        aw_got_q;
    logic        w_got_q;
    logic        b_pend_q;

    // fill pattern spreads over every word address.
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h9e3779b9 * (i + 1);
        end
    end

    // stall bits: ar, r, aw, w, b.
    assign arready_o = ~stall_i[0];
    assign rvalid_o  = rd_pend_q & ~stall_i[1];
    assign rdata_o   = mem[rd_idx_q];
    assign awready_o = ~stall_i[2] & ~aw_got_q;
    assign wready_o  = ~stall_i[3] & ~w_got_q;
    assign bvalid_o  = b_pend_q & ~stall_i[4];

    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            rd_pend_q <= 1'b0;
            aw_got_q  <= 1'b0;
            w_got_q   <= 1'b0;
            b_pend_q  <= 1'b0;
        end else begin
            if (arvalid_i && arready_o) begin
                rd_pend_q <= 1'b1;
                rd_idx_q  <= araddr_i[7:2];
            end else if (rvalid_o && rready_i) begin
                rd_pend_q <= 1'b0;
            end
            if (awvalid_i && awready_o) begin
                aw_got_q <= 1'b1;
                wr_idx_q <= awaddr_i[7:2];
            end
            if (wvalid_i && wready_o) begin
                w_got_q <= 1'b1;
                wdata_q <= wdata_i;
                wstrb_q <= wstrb_i;
            end
            // both halves in, commit the masked write.
            if (aw_got_q && w_got_q) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb_q[b]) begin
                        mem[wr_idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
                    end
                end
                aw_got_q <= 1'b0;
                w_got_q  <= 1'b0;
                b_pend_q <= 1'b1;
            end
            if (bvalid_o && bready_i) begin
                b_pend_q <= 1'b0;
            end
        end
    end

endmodule

//--- hw/mem_bridge_top.sv
`timescale 1ns/10ps

module mem_bridge_top (
    input  logic                    Clk,
    input  logic                    aresetn,

    input  logic                    inst_req_i,
    input  mem_bridge_pkg::addr_t   inst_addr_i,
    output logic                    inst_addr_ok_o,
    output logic                    inst_data_ok_o,
    output mem_bridge_pkg::word_t   inst_rdata_o,

    input  logic                    data_req_i,
    input  logic                    data_wr_i,
    input  mem_bridge_pkg::size_t   data_size_i,
    input  mem_bridge_pkg::addr_t   data_addr_i,
    input  mem_bridge_pkg::word_t   data_wdata_i,
    output logic                    data_addr_ok_o,
    output logic                    data_data_ok_o,
    output mem_bridge_pkg::word_t   data_rdata_o,

    output mem_bridge_pkg::axi_id_t arid_o,
    output mem_bridge_pkg::addr_t   araddr_o,
    output mem_bridge_pkg::size_t   arsize_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,
    input  mem_bridge_pkg::word_t   rdata_i,
    input  logic                    rvalid_i,
    output logic                    rready_o,
    output mem_bridge_pkg::addr_t   awaddr_o,
    output mem_bridge_pkg::size_t   awsize_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output mem_bridge_pkg::word_t   wdata_o,
    output mem_bridge_pkg::strb_t   wstrb_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,
    input  logic                    bvalid_i,
    output logic                    bready_o
);

    logic                    bridge_ready;

    // ******************************
    // arbiter to engine
    // ******************************
    logic                    start;
    logic                    is_write;
    mem_bridge_pkg::addr_t   req_addr;
    mem_bridge_pkg::size_t   req_size;
    mem_bridge_pkg::word_t   req_wdata;
    mem_bridge_pkg::strb_t   req_strb;
    mem_bridge_pkg::axi_id_t req_id;
    logic                    done;
    mem_bridge_pkg::word_t   done_rdata;

    reset_stretch i_reset_stretch (
        .Clk     (Clk),
        .aresetn (aresetn),
        .ready_o (bridge_ready)
    );

    req_arbiter i_req_arbiter (
        .Clk            (Clk),
        .aresetn        (aresetn),
        .ready_i        (bridge_ready),
        .inst_req_i     (inst_req_i),
        .inst_addr_i    (inst_addr_i),
        .inst_addr_ok_o (inst_addr_ok_o),
        .inst_data_ok_o (inst_data_ok_o),
        .inst_rdata_o   (inst_rdata_o),
        .data_req_i     (data_req_i),
        .data_wr_i      (data_wr_i),
        .data_size_i    (data_size_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_addr_ok_o (data_addr_ok_o),
        .data_data_ok_o (data_data_ok_o),
        .data_rdata_o   (data_rdata_o),
        .start_o        (start),
        .is_write_o     (is_write),
        .addr_o         (req_addr),
        .size_o         (req_size),
        .wdata_o        (req_wdata),
        .strb_o         (req_strb),
        .id_o           (req_id),
        .done_i         (done),
        .rdata_i        (done_rdata)
    );

    axi_single_beat i_axi_single_beat (
        .Clk        (Clk),
        .aresetn    (aresetn),
        .start_i    (start),
        .is_write_i (is_write),
        .addr_i     (req_addr),
        .size_i     (req_size),
        .wdata_i    (req_wdata),
        .strb_i     (req_strb),
        .id_i       (req_id),
        .done_o     (done),
        .rdata_o    (done_rdata),
        .arid_o     (arid_o),
        .araddr_o   (araddr_o),
        .arsize_o   (arsize_o),
        .arvalid_o  (arvalid_o),
        .arready_i  (arready_i),
        .rdata_i    (rdata_i),
        .rvalid_i   (rvalid_i),
        .rready_o   (rready_o),
        .awaddr_o   (awaddr_o),
        .awsize_o   (awsize_o),
        .awvalid_o  (awvalid_o),
        .awready_i  (awready_i),
        .wdata_o    (wdata_o),
        .wstrb_o    (wstrb_o),
        .wvalid_o   (wvalid_o),
        .wready_i   (wready_i),
        .bvalid_i   (bvalid_i),
        .bready_o   (bready_o)
    );

endmodule

//--- hw/axi_single_beat.sv
`timescale 1ns/10ps

module axi_single_beat (
    input  logic                    Clk,
    input  logic                    aresetn,

    input  logic                    start_i,
    input  logic                    is_write_i,
    input  mem_bridge_pkg::addr_t   addr_i,
    input  mem_bridge_pkg::size_t   size_i,
    input  mem_bridge_pkg::word_t   wdata_i,
    input  mem_bridge_pkg::strb_t   strb_i,
    input  mem_bridge_pkg::axi_id_t id_i,
    output logic                    done_o,
    output mem_bridge_pkg::word_t   rdata_o,

    output mem_bridge_pkg::axi_id_t arid_o,
    output mem_bridge_pkg::addr_t   araddr_o,
    output mem_bridge_pkg::size_t   arsize_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,

    input  mem_bridge_pkg::word_t   rdata_i,
    input  logic                    rvalid_i,
    output logic                    rready_o,

    output mem_bridge_pkg::addr_t   awaddr_o,
    output mem_bridge_pkg::size_t   awsize_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,

    output mem_bridge_pkg::word_t   wdata_o,
    output mem_bridge_pkg::strb_t   wstrb_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,

    input  logic                    bvalid_i,
    output logic                    bready_o
);

    mem_bridge_pkg::axi_state_t state_q;
    logic                       aw_done_q;
    logic                       w_done_q;
    logic                       aw_hs;
    logic                       w_hs;
    logic                       aw_taken;
    logic                       w_taken;

    mem_bridge_pkg::addr_t      addr_q;
    mem_bridge_pkg::size_t      size_q;
    mem_bridge_pkg::word_t      wdata_q;
    mem_bridge_pkg::strb_t      strb_q;
    mem_bridge_pkg::axi_id_t    id_q;

    // ******************************
    // channel outputs
    // ******************************
    assign arid_o    = id_q;
    assign araddr_o  = addr_q;
    assign arsize_o  = size_q;
    assign arvalid_o = (state_q == mem_bridge_pkg::AXI_AR);
    assign rready_o  = (state_q == mem_bridge_pkg::AXI_R);

    assign awaddr_o  = addr_q;
    assign awsize_o  = size_q;
    assign wdata_o   = wdata_q;
    assign wstrb_o   = strb_q;

    // aw and w drop independently on their own ready.
    assign awvalid_o = (state_q == mem_bridge_pkg::AXI_AW_W) & ~aw_done_q;
    assign wvalid_o  = (state_q == mem_bridge_pkg::AXI_AW_W) & ~w_done_q;
    assign bready_o  = (state_q == mem_bridge_pkg::AXI_B);

    assign aw_hs    = awvalid_o & awready_i;
    assign w_hs     = wvalid_o & wready_i;
    assign aw_taken = aw_done_q | aw_hs;
    assign w_taken  = w_done_q | w_hs;

    // ******************************
    // state machine
    // ******************************
    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            state_q   <= mem_bridge_pkg::AXI_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                mem_bridge_pkg::AXI_IDLE: begin
                    if (start_i) begin
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        state_q   <= is_write_i ? mem_bridge_pkg::AXI_AW_W
                                                : mem_bridge_pkg::AXI_AR;
                    end
                end
                mem_bridge_pkg::AXI_AR: begin
                    if (arready_i) begin
                        state_q <= mem_bridge_pkg::AXI_R;
                    end
                end
                mem_bridge_pkg::AXI_R: begin
                    if (rvalid_i) begin
                        state_q <= mem_bridge_pkg::AXI_IDLE;
                        done_o  <= 1'b1;
                    end
                end
                mem_bridge_pkg::AXI_AW_W: begin
                    aw_done_q <= aw_taken;
                    w_done_q  <= w_taken;
                    if (aw_taken & w_taken) begin
                        state_q <= mem_bridge_pkg::AXI_B;
                    end
                end
                mem_bridge_pkg::AXI_B: begin
                    if (bvalid_i) begin
                        state_q <= mem_bridge_pkg::AXI_IDLE;
                        done_o  <= 1'b1;
                    end
                end
                default: begin
                    state_q <= mem_bridge_pkg::AXI_IDLE;
                end
            endcase
        end
    end

    // payload captured at start, read data at the r handshake.
    always_ff @(posedge Clk) begin
        if ((state_q == mem_bridge_pkg::AXI_IDLE) && start_i) begin
            addr_q  <= addr_i;
            size_q  <= size_i;
            wdata_q <= wdata_i;
            strb_q  <= strb_i;
            id_q    <= id_i;
        end
        if (rready_o && rvalid_i) begin
            rdata_o <= rdata_i;
        end
    end

endmodule

//--- hw/req_arbiter.sv
`timescale 1ns/10ps

module req_arbiter (
    input  logic                    Clk,
    input  logic                    aresetn,
    input  logic                    ready_i,

    input  logic                    inst_req_i,
    input  mem_bridge_pkg::addr_t   inst_addr_i,
    output logic                    inst_addr_ok_o,
    output logic                    inst_data_ok_o,
    output mem_bridge_pkg::word_t   inst_rdata_o,

    input  logic                    data_req_i,
    input  logic                    data_wr_i,
    input  mem_bridge_pkg::size_t   data_size_i,
    input  mem_bridge_pkg::addr_t   data_addr_i,
    input  mem_bridge_pkg::word_t   data_wdata_i,
    output logic                    data_addr_ok_o,
    output logic                    data_data_ok_o,
    output mem_bridge_pkg::word_t   data_rdata_o,

    output logic                    start_o,
    output logic                    is_write_o,
    output mem_bridge_pkg::addr_t   addr_o,
    output mem_bridge_pkg::size_t   size_o,
    output mem_bridge_pkg::word_t   wdata_o,
    output mem_bridge_pkg::strb_t   strb_o,
    output mem_bridge_pkg::axi_id_t id_o,

    input  logic                    done_i,
    input  mem_bridge_pkg::word_t   rdata_i
);

    mem_bridge_pkg::arb_state_t state_q;
    logic                       owner_data_q;
    logic                       busy_done;
    logic                       slot_free;
    logic                       take_data;
    logic                       take_inst;
    mem_bridge_pkg::strb_t      data_strb;

    // ******************************
    // owner selection
    // ******************************
    // the slot frees in the same cycle the engine reports done.
    assign busy_done = (state_q == mem_bridge_pkg::ARB_WAIT) & done_i;
    assign slot_free = ready_i & ((state_q == mem_bridge_pkg::ARB_IDLE) | busy_done);

    // data wins a tie.
    assign take_data = slot_free & data_req_i;
    assign take_inst = slot_free & inst_req_i & ~data_req_i;

    assign data_addr_ok_o = take_data;
    assign inst_addr_ok_o = take_inst;

    // ******************************
    // completion
    // ******************************
    assign data_data_ok_o = busy_done & owner_data_q;
    assign inst_data_ok_o = busy_done & ~owner_data_q;
    assign data_rdata_o   = rdata_i;
    assign inst_rdata_o   = rdata_i;

    // byte lanes from size and low address bits.
    always_comb begin
        case (data_size_i)
            mem_bridge_pkg::SIZE_BYTE: data_strb = 4'b0001 << data_addr_i[1:0];
            mem_bridge_pkg::SIZE_HALF: data_strb = data_addr_i[1] ? 4'b1100 : 4'b0011;
            default:                   data_strb = 4'b1111;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            state_q      <= mem_bridge_pkg::ARB_IDLE;
            owner_data_q <= 1'b0;
            start_o      <= 1'b0;
        end else begin
            start_o <= take_data | take_inst;
            if (take_data | take_inst) begin
                state_q      <= mem_bridge_pkg::ARB_WAIT;
                owner_data_q <= take_data;
            end else if (busy_done) begin
                state_q <= mem_bridge_pkg::ARB_IDLE;
            end
        end
    end

    // transfer fields, held until the next acceptance.
    always_ff @(posedge Clk) begin
        if (take_data) begin
            is_write_o <= data_wr_i;
            addr_o     <= data_addr_i;
            size_o     <= data_size_i;
            wdata_o    <= data_wdata_i;
            strb_o     <= data_strb;
            id_o       <= mem_bridge_pkg::ID_DATA;
        end else if (take_inst) begin
            is_write_o <= 1'b0;
            addr_o     <= inst_addr_i;
            size_o     <= mem_bridge_pkg::SIZE_WORD;
            strb_o     <= '0;
            id_o       <= mem_bridge_pkg::ID_INST;
        end
    end

endmodule

//--- hw/reset_stretch.sv
`timescale 1ns/10ps

module reset_stretch (
    input  logic Clk,
    input  logic aresetn,
    output logic ready_o
);

    logic [mem_bridge_pkg::STRETCH_W-1:0] cnt_q;
    logic                                 ready_q;

    // counts from the first edge that sees aresetn high.
    // ready is set on the edge after the counter saturates.
    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            cnt_q   <= '0;
            ready_q <= 1'b0;
        end else if (!ready_q) begin
            if (int'(cnt_q) == mem_bridge_pkg::STRETCH_CYCLES - 1) begin
                ready_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign ready_o = ready_q;

endmodule

//--- hw/mem_bridge_pkg.sv
package mem_bridge_pkg;

    // ******************************
    // widths
    // ******************************
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        size_t;
    typedef logic [ID_W-1:0]   axi_id_t;

    // ******************************
    // state machines
    // ******************************
    typedef enum logic [0:0] {
        ARB_IDLE,
        ARB_WAIT
    } arb_state_t;

    typedef enum logic [2:0] {
        AXI_IDLE,
        AXI_AR,
        AXI_R,
        AXI_AW_W,
        AXI_B
    } axi_state_t;

    // size codes, same encoding as arsize/awsize.
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // read ids tell fetches from loads.
    localparam axi_id_t ID_INST = 4'd0;
    localparam axi_id_t ID_DATA = 4'd1;

    // idle time after reset release.
    localparam int STRETCH_W      = 7;
    localparam int STRETCH_CYCLES = 128;

endpackage
